// File: mont_data_pkg.sv
package mont_data_pkg;

    // radix-4 digit, two bits of A per iteration
    localparam int DIGIT_W = 2;

    // which multiple the bank puts on its output
    typedef enum logic [2:0] {
        SEL_ZERO,
        SEL_B,
        SEL_2B,
        SEL_3B,
        SEL_M,
        SEL_2M,
        SEL_3M
    } mult_sel_t;

    // accumulator update per cycle
    typedef enum logic [2:0] {
        ACC_HOLD,
        ACC_CLEAR,
        ACC_LOAD_MULT,
        ACC_SUM,
        ACC_SUM_SHIFT,  // sum >> DIGIT_W
        ACC_SUM_IF_POS  // final reduction, only when sum >= 0
    } acc_op_t;

endpackage

// File: mont_ctrl_pkg.sv
package mont_ctrl_pkg;

    // top level sequencing of one multiplication
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,       // capture operands and 2x multiples
        ST_PREP_B3,    // 3B = B + 2B
        ST_PREP_M3,    // 3M = M + 2M
        ST_ADD_B,      // acc += digit(A) * B
        ST_ADD_M,      // acc = (acc + q * M) >> 2
        ST_FINAL_SUB,
        ST_DONE
    } mont_state_t;

endpackage

// File: multiple_bank.sv
`timescale 1ns/1ps

module multiple_bank #(
    parameter int  WIDTH = 1024,
    localparam int ACC_W = WIDTH + 4
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     load_inputs,
    input  logic                     write_b3,
    input  logic                     write_m3,
    input  logic [WIDTH-1:0]         in_b,
    input  logic [WIDTH-1:0]         in_m,
    input  logic [ACC_W-1:0]         sum,
    input  mont_data_pkg::mult_sel_t mult_sel,
    output logic [ACC_W-1:0]         mult_out
);

    import mont_data_pkg::*;

    logic [ACC_W-1:0] b1_q;
    logic [ACC_W-1:0] b2_q;
    logic [ACC_W-1:0] b3_q;
    logic [ACC_W-1:0] m1_q;
    logic [ACC_W-1:0] m2_q;
    logic [ACC_W-1:0] m3_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            b1_q <= '0;
            b2_q <= '0;
            b3_q <= '0;
            m1_q <= '0;
            m2_q <= '0;
            m3_q <= '0;
        end else begin
            if (load_inputs) begin
                b1_q <= {{(ACC_W-WIDTH){1'b0}}, in_b};
                b2_q <= {{(ACC_W-WIDTH-1){1'b0}}, in_b, 1'b0};  // 2B by shift
                m1_q <= {{(ACC_W-WIDTH){1'b0}}, in_m};
                m2_q <= {{(ACC_W-WIDTH-1){1'b0}}, in_m, 1'b0};
            end
            // 3x values come back from the shared adder
            if (write_b3) begin
                b3_q <= sum;
            end
            if (write_m3) begin
                m3_q <= sum;
            end
        end
    end

    always_comb begin
        case (mult_sel)
            SEL_B:   mult_out = b1_q;
            SEL_2B:  mult_out = b2_q;
            SEL_3B:  mult_out = b3_q;
            SEL_M:   mult_out = m1_q;
            SEL_2M:  mult_out = m2_q;
            SEL_3M:  mult_out = m3_q;
            default: mult_out = '0;  // SEL_ZERO
        endcase
    end

endmodule

// File: mp_adder.sv
`timescale 1ns/1ps

module mp_adder #(
    parameter int  WIDTH = 1024,
    parameter int  CHUNK = 64,
    localparam int ACC_W = WIDTH + 4
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             add_start,
    input  logic             subtract,
    input  logic [ACC_W-1:0] x,
    input  logic [ACC_W-1:0] y,
    output logic [ACC_W-1:0] sum,
    output logic             add_done
);

    localparam int SLICES = (ACC_W + CHUNK - 1) / CHUNK;
    localparam int PAD_W  = SLICES * CHUNK;
    localparam int IDX_W  = (SLICES > 1) ? $clog2(SLICES) : 1;

    logic [PAD_W-1:0] x_pad;
    logic [PAD_W-1:0] y_pad;
    logic [PAD_W-1:0] sum_pad;
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] cur_idx;
    logic             running;
    logic             carry;
    logic             sub_q;
    logic             cur_sub;
    logic             cur_cin;
    logic             last_slice;
    logic [CHUNK-1:0] x_slice;
    logic [CHUNK-1:0] y_slice;
    logic [CHUNK:0]   slice_sum;

    assign x_pad = PAD_W'(x);
    assign y_pad = PAD_W'(y);

    // slice 0 is handled in the start cycle itself
    assign cur_idx    = add_start ? '0 : idx;
    assign cur_sub    = add_start ? subtract : sub_q;
    assign cur_cin    = add_start ? subtract : carry;  // +1 completes the two's complement
    assign last_slice = (cur_idx == IDX_W'(SLICES - 1));

    assign x_slice   = x_pad[cur_idx*CHUNK +: CHUNK];
    assign y_slice   = cur_sub ? ~y_pad[cur_idx*CHUNK +: CHUNK] : y_pad[cur_idx*CHUNK +: CHUNK];
    assign slice_sum = x_slice + y_slice + cur_cin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            running  <= 1'b0;
            idx      <= '0;
            carry    <= 1'b0;
            sub_q    <= 1'b0;
            add_done <= 1'b0;
        end else begin
            add_done <= 1'b0;
            if (add_start) begin
                sub_q <= subtract;
            end
            if (add_start || running) begin
                carry <= slice_sum[CHUNK];
                idx   <= cur_idx + 1'b1;
                if (last_slice) begin
                    running  <= 1'b0;
                    add_done <= 1'b1;  // one pulse, SLICES cycles after start
                end else begin
                    running <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (add_start || running) begin
            sum_pad[cur_idx*CHUNK +: CHUNK] <= slice_sum[CHUNK-1:0];
        end
    end

    // padding bits above ACC_W are dropped
    assign sum = sum_pad[ACC_W-1:0];

endmodule

// File: mont_datapath.sv
`timescale 1ns/1ps

module mont_datapath #(
    parameter int  WIDTH = 1024,
    localparam int ACC_W = WIDTH + 4
) (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                load_inputs,
    input  logic                                shift_a,
    input  logic [WIDTH-1:0]                    in_a,
    input  mont_data_pkg::acc_op_t              acc_op,
    input  logic [ACC_W-1:0]                    mult_out,
    input  logic [ACC_W-1:0]                    sum,
    output logic [ACC_W-1:0]                    acc,
    output logic [mont_data_pkg::DIGIT_W-1:0]   a_digit,
    output logic [mont_data_pkg::DIGIT_W-1:0]   acc_low,
    output logic [WIDTH-1:0]                    result
);

    import mont_data_pkg::*;

    logic [WIDTH-1:0] a_q;
    logic             sum_neg;

    assign sum_neg = sum[ACC_W-1];  // sign of acc - M in the final step

    // accumulator, also holds the result between operations
    always_ff @(posedge clk) begin
        if (!resetn) begin
            acc <= '0;
        end else begin
            case (acc_op)
                ACC_CLEAR:      acc <= '0;
                ACC_LOAD_MULT:  acc <= mult_out;
                ACC_SUM:        acc <= sum;
                ACC_SUM_SHIFT:  acc <= sum >> DIGIT_W;  // low bits are zero here
                ACC_SUM_IF_POS: begin
                    if (!sum_neg) begin
                        acc <= sum;
                    end
                end
                default:        acc <= acc;
            endcase
        end
    end

    // A is scanned two bits at a time from the bottom
    always_ff @(posedge clk) begin
        if (load_inputs) begin
            a_q <= in_a;
        end else if (shift_a) begin
            a_q <= a_q >> DIGIT_W;
        end
    end

    assign a_digit = a_q[DIGIT_W-1:0];
    assign acc_low = acc[DIGIT_W-1:0];
    assign result  = acc[WIDTH-1:0];

endmodule

// File: mont_ctrl.sv
`timescale 1ns/1ps

module mont_ctrl #(
    parameter int WIDTH = 1024
) (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              start,
    input  logic                              add_done,
    input  logic [mont_data_pkg::DIGIT_W-1:0] a_digit,
    input  logic [mont_data_pkg::DIGIT_W-1:0] acc_low,
    input  logic [mont_data_pkg::DIGIT_W-1:0] m_low,
    output logic                              done,
    output logic                              busy,
    output logic                              load_inputs,
    output logic                              write_b3,
    output logic                              write_m3,
    output logic                              shift_a,
    output logic                              add_start,
    output logic                              subtract,
    output mont_data_pkg::mult_sel_t          mult_sel,
    output mont_data_pkg::acc_op_t            acc_op
);

    import mont_data_pkg::*;
    import mont_ctrl_pkg::*;

    localparam int ITERS  = WIDTH / DIGIT_W;
    localparam int ITER_W = (ITERS > 1) ? $clog2(ITERS) : 1;

    mont_state_t              state;
    mont_state_t              next_state;
    logic                     waiting;  // 0 is the setup cycle, 1 an addition in flight
    logic                     add_state;
    logic                     last_iter;
    logic [ITER_W-1:0]        iter_cnt;
    logic [DIGIT_W-1:0]       m_low_q;
    logic [2*DIGIT_W-1:0]     q_prod;
    logic [DIGIT_W-1:0]       q_digit;
    mult_sel_t                a_sel;
    mult_sel_t                q_sel;

    assign add_state = (state == ST_PREP_B3) || (state == ST_PREP_M3) || (state == ST_ADD_B)
                    || (state == ST_ADD_M) || (state == ST_FINAL_SUB);
    assign last_iter = (iter_cnt == ITER_W'(ITERS - 1));

    // m is odd so m mod 4 is its own inverse mod 4
    assign q_prod  = acc_low * m_low_q;
    assign q_digit = ~q_prod[DIGIT_W-1:0] + 1'b1;

    always_comb begin
        case (a_digit)
            2'd1:    a_sel = SEL_B;
            2'd2:    a_sel = SEL_2B;
            2'd3:    a_sel = SEL_3B;
            default: a_sel = SEL_ZERO;
        endcase
    end

    always_comb begin
        case (q_digit)
            2'd1:    q_sel = SEL_M;
            2'd2:    q_sel = SEL_2M;
            2'd3:    q_sel = SEL_3M;
            default: q_sel = SEL_ZERO;
        endcase
    end

    always_comb begin
        next_state  = state;
        load_inputs = 1'b0;
        write_b3    = 1'b0;
        write_m3    = 1'b0;
        shift_a     = 1'b0;
        mult_sel    = SEL_ZERO;
        acc_op      = ACC_HOLD;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    next_state = ST_LOAD;
                end
            end
            ST_LOAD: begin
                load_inputs = 1'b1;
                next_state  = ST_PREP_B3;
            end
            ST_PREP_B3: begin
                if (!waiting) begin
                    mult_sel = SEL_B;  // acc = B, then add 2B
                    acc_op   = ACC_LOAD_MULT;
                end else begin
                    mult_sel = SEL_2B;
                    if (add_done) begin
                        write_b3   = 1'b1;
                        next_state = ST_PREP_M3;
                    end
                end
            end
            ST_PREP_M3: begin
                if (!waiting) begin
                    mult_sel = SEL_M;
                    acc_op   = ACC_LOAD_MULT;
                end else begin
                    mult_sel = SEL_2M;
                    if (add_done) begin
                        write_m3   = 1'b1;
                        acc_op     = ACC_CLEAR;  // loop starts from zero
                        next_state = ST_ADD_B;
                    end
                end
            end
            ST_ADD_B: begin
                mult_sel = a_sel;
                if (waiting && add_done) begin
                    acc_op     = ACC_SUM;
                    next_state = ST_ADD_M;
                end
            end
            ST_ADD_M: begin
                mult_sel = q_sel;  // clears the two low bits of acc
                if (waiting && add_done) begin
                    acc_op     = ACC_SUM_SHIFT;
                    shift_a    = 1'b1;
                    next_state = last_iter ? ST_FINAL_SUB : ST_ADD_B;
                end
            end
            ST_FINAL_SUB: begin
                mult_sel = SEL_M;
                if (waiting && add_done) begin
                    acc_op     = ACC_SUM_IF_POS;
                    next_state = ST_DONE;
                end
            end
            default: begin
                next_state = ST_IDLE;  // ST_DONE
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= ST_IDLE;
            waiting   <= 1'b0;
            add_start <= 1'b0;
            iter_cnt  <= '0;
        end else begin
            state     <= next_state;
            add_start <= add_state && !waiting;  // issued on the first waiting cycle
            if (add_state && !waiting) begin
                waiting <= 1'b1;
            end else if (add_done) begin
                waiting <= 1'b0;
            end
            if (load_inputs) begin
                iter_cnt <= '0;
            end else if (shift_a) begin
                iter_cnt <= iter_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_inputs) begin
            m_low_q <= m_low;
        end
    end

    assign subtract = (state == ST_FINAL_SUB);
    assign done     = (state == ST_DONE);
    assign busy     = (state != ST_IDLE);

endmodule

// File: montgomery.sv
`timescale 1ns/1ps

module montgomery #(
    parameter int WIDTH = 1024,
    parameter int CHUNK = 64
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             start,
    input  logic [WIDTH-1:0] in_a,
    input  logic [WIDTH-1:0] in_b,
    input  logic [WIDTH-1:0] in_m,
    output logic [WIDTH-1:0] result,
    output logic             done,
    output logic             busy
);

    import mont_data_pkg::*;

    localparam int ACC_W = WIDTH + 4;

    logic               load_inputs;
    logic               write_b3;
    logic               write_m3;
    logic               shift_a;
    logic               add_start;
    logic               add_done;
    logic               subtract;
    logic [DIGIT_W-1:0] a_digit;
    logic [DIGIT_W-1:0] acc_low;
    logic [ACC_W-1:0]   acc;
    logic [ACC_W-1:0]   mult_out;
    logic [ACC_W-1:0]   sum;
    mult_sel_t          mult_sel;
    acc_op_t            acc_op;

    mont_ctrl #(
        .WIDTH (WIDTH)
    ) mont_ctrl_inst (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .add_done    (add_done),
        .a_digit     (a_digit),
        .acc_low     (acc_low),
        .m_low       (in_m[DIGIT_W-1:0]),
        .done        (done),
        .busy        (busy),
        .load_inputs (load_inputs),
        .write_b3    (write_b3),
        .write_m3    (write_m3),
        .shift_a     (shift_a),
        .add_start   (add_start),
        .subtract    (subtract),
        .mult_sel    (mult_sel),
        .acc_op      (acc_op)
    );

    multiple_bank #(
        .WIDTH (WIDTH)
    ) multiple_bank_inst (
        .clk         (clk),
        .resetn      (resetn),
        .load_inputs (load_inputs),
        .write_b3    (write_b3),
        .write_m3    (write_m3),
        .in_b        (in_b),
        .in_m        (in_m),
        .sum         (sum),
        .mult_sel    (mult_sel),
        .mult_out    (mult_out)
    );

    mont_datapath #(
        .WIDTH (WIDTH)
    ) mont_datapath_inst (
        .clk         (clk),
        .resetn      (resetn),
        .load_inputs (load_inputs),
        .shift_a     (shift_a),
        .in_a        (in_a),
        .acc_op      (acc_op),
        .mult_out    (mult_out),
        .sum         (sum),
        .acc         (acc),
        .a_digit     (a_digit),
        .acc_low     (acc_low),
        .result      (result)
    );

    // accumulator on x, selected multiple on y
    mp_adder #(
        .WIDTH (WIDTH),
        .CHUNK (CHUNK)
    ) mp_adder_inst (
        .clk       (clk),
        .resetn    (resetn),
        .add_start (add_start),
        .subtract  (subtract),
        .x         (acc),
        .y         (mult_out),
        .sum       (sum),
        .add_done  (add_done)
    );

endmodule

// File: tb_montgomery.sv
`timescale 1ns/1ps

module tb_montgomery;

    import mont_data_pkg::*;

    localparam int WIDTH   = 128;
    localparam int CHUNK   = 32;
    localparam int TIMEOUT = 5000;  // cycles allowed per operation

    typedef logic [WIDTH+7:0] wide_t;  // headroom for the model sums

    logic             clk;
    logic             resetn;
    logic             start;
    logic [WIDTH-1:0] in_a;
    logic [WIDTH-1:0] in_b;
    logic [WIDTH-1:0] in_m;
    logic [WIDTH-1:0] result;
    logic             done;
    logic             busy;
    integer           seed;

    montgomery #(
        .WIDTH (WIDTH),
        .CHUNK (CHUNK)
    ) montgomery_inst (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .result (result),
        .done   (done),
        .busy   (busy)
    );

    always #2 clk = ~clk;

    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    // inputs change and outputs are read 1 ns after the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_result(input string name, input logic [WIDTH-1:0] expected,
                                input logic [WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %s expected %b actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    // radix-4 Montgomery rule with one digit of a per round
    task automatic compute_expected(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                                    input logic [WIDTH-1:0] m, output logic [WIDTH-1:0] res);
        wide_t              t;
        logic [DIGIT_W-1:0] d;
        int                 i;
        int                 k;
        t = '0;
        for (i = 0; i < WIDTH / DIGIT_W; i++) begin
            d = a[i*DIGIT_W +: DIGIT_W];
            t = t + wide_t'(d) * wide_t'(b);
            // add m at most three times until the two low bits clear
            for (k = 0; k < 3; k++) begin
                if (t[DIGIT_W-1:0] != '0) begin
                    t = t + wide_t'(m);
                end
            end
            t = t >> DIGIT_W;
        end
        if (t >= wide_t'(m)) begin
            t = t - wide_t'(m);
        end
        res = t[WIDTH-1:0];
    endtask

    task automatic rand_word(output logic [WIDTH-1:0] v);
        int j;
        for (j = 0; j < WIDTH / 32; j++) begin
            v[j*32 +: 32] = $random(seed);
        end
    endtask

    task automatic wait_done(input string name);
        int n;
        n = 0;
        while (!done && n < TIMEOUT) begin
            check_bit({name, " busy while running"}, 1'b1, busy);
            step();
            n++;
        end
        if (!done) begin
            $display("timeout: no done pulse within %0d cycles in test %s", TIMEOUT, name);
            abort_run();
        end
        check_bit({name, " busy with done"}, 1'b1, busy);
    endtask

    task automatic run_op(input string name, input logic [WIDTH-1:0] a,
                          input logic [WIDTH-1:0] b, input logic [WIDTH-1:0] m,
                          output logic [WIDTH-1:0] res);
        in_a  = a;
        in_b  = b;
        in_m  = m;
        start = 1'b1;
        step();
        start = 1'b0;
        check_bit({name, " busy after start"}, 1'b1, busy);
        wait_done(name);
        res = result;
        step();
        check_bit({name, " done length"}, 1'b0, done);  // single cycle pulse
        check_bit({name, " busy after done"}, 1'b0, busy);
    endtask

    task automatic run_and_check(input string name, input logic [WIDTH-1:0] a,
                                 input logic [WIDTH-1:0] b, input logic [WIDTH-1:0] m);
        logic [WIDTH-1:0] expected;
        logic [WIDTH-1:0] res;
        compute_expected(a, b, m, expected);
        run_op(name, a, b, m, res);
        check_bit({name, " below m"}, 1'b1, res < m);
        check_result(name, expected, res);
    endtask

    task automatic random_operands(output logic [WIDTH-1:0] a, output logic [WIDTH-1:0] b,
                                   output logic [WIDTH-1:0] m);
        rand_word(m);
        m[0] = 1'b1;  // odd modulus
        rand_word(a);
        rand_word(b);
        a = a % m;
        b = b % m;
    endtask

    task automatic test_zero_operand();
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        logic [WIDTH-1:0] m;
        logic [WIDTH-1:0] res;
        random_operands(a, b, m);
        run_op("zero operand", '0, b, m, res);
        check_result("zero operand", '0, res);
    endtask

    task automatic test_identity();
        logic [WIDTH-1:0] m;
        run_and_check("identity m=3", 1, 1, 3);
        run_and_check("identity m=all ones", 1, 1, '1);
        run_and_check("identity m=2^127+1", 1, 1, {1'b1, {(WIDTH-2){1'b0}}, 1'b1});
        rand_word(m);
        m[0] = 1'b1;
        run_and_check("identity m=random", 1, 1, m);
    endtask

    task automatic test_random();
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        logic [WIDTH-1:0] m;
        int               i;
        for (i = 0; i < 25; i++) begin
            random_operands(a, b, m);
            run_and_check($sformatf("random %0d", i), a, b, m);
        end
    endtask

    // largest operands against a modulus near the top of the range
    task automatic test_final_sub_edge();
        logic [WIDTH-1:0] m;
        m = '1;
        run_and_check("edge m=2^128-1", m - 1, m - 1, m);
        m = '1 - 158;
        run_and_check("edge m=2^128-159", m - 1, m - 1, m);
    endtask

    task automatic test_handshake();
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        logic [WIDTH-1:0] m;
        logic [WIDTH-1:0] expected;
        logic [WIDTH-1:0] res;
        int               i;
        random_operands(a, b, m);
        compute_expected(a, b, m, expected);
        in_a  = a;
        in_b  = b;
        in_m  = m;
        start = 1'b1;
        step();
        start = 1'b0;
        check_bit("handshake busy after start", 1'b1, busy);
        repeat (5) step();
        in_a  = ~a;  // a second start with other operands must be ignored
        in_b  = ~b;
        start = 1'b1;
        step();
        start = 1'b0;
        wait_done("handshake");
        res = result;
        check_result("handshake", expected, res);
        step();
        check_bit("handshake done length", 1'b0, done);
        check_bit("handshake busy after done", 1'b0, busy);
        for (i = 0; i < 8; i++) begin
            in_a = WIDTH'(i);
            step();
            check_result("handshake result hold", res, result);
            check_bit("handshake idle", 1'b0, busy);
        end
    endtask

    task automatic test_reset_mid_op();
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        logic [WIDTH-1:0] m;
        int               i;
        random_operands(a, b, m);
        in_a  = a;
        in_b  = b;
        in_m  = m;
        start = 1'b1;
        step();
        start = 1'b0;
        repeat (60) step();
        resetn = 1'b0;
        for (i = 0; i < 4; i++) begin
            step();
            check_bit("reset mid op done", 1'b0, done);
            check_bit("reset mid op busy", 1'b0, busy);
        end
        resetn = 1'b1;
        check_result("reset mid op result", '0, result);
        run_and_check("after reset", a, b, m);
    endtask

    initial begin
        seed   = 32'h8de73c34;
        clk    = 1'b0;
        resetn = 1'b0;
        start  = 1'b0;
        in_a   = '0;
        in_b   = '0;
        in_m   = '0;
        repeat (4) @(posedge clk);
        #1;
        resetn = 1'b1;
        check_bit("reset done", 1'b0, done);
        check_bit("reset busy", 1'b0, busy);
        check_result("reset result", '0, result);
        test_zero_operand();
        test_identity();
        test_random();
        test_final_sub_edge();
        test_handshake();
        test_reset_mid_op();
        $display("all tests passed");
        $finish;
    end

endmodule

// File: src.f
mont_data_pkg.sv
mont_ctrl_pkg.sv
multiple_bank.sv
mp_adder.sv
mont_datapath.sv
mont_ctrl.sv
montgomery.sv
tb_montgomery.sv

// File: Makefile
TOP = tb_montgomery
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "all tests passed" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
